// ==== include/ipod_macros.svh ====
`ifndef IPOD_MACROS_SVH
`define IPOD_MACROS_SVH

// ======================================================================
// Sample period limits and step
// ======================================================================

// Width of the sample period register
`define IPOD_PERIOD_W 16

// Reset period, about 2 kHz half-period rate at 50 MHz
`define IPOD_DEFAULT_PERIOD 12499

// Change applied per speed command
`define IPOD_PERIOD_STEP 100

// Clamp values
`define IPOD_MIN_PERIOD 2499
`define IPOD_MAX_PERIOD 49999

// ======================================================================
// Key event rate and output widths
// ======================================================================

// Key ticks per up/down command window
`define IPOD_EVENT_GAP_TICKS 100

// Signed test audio sample width
`define IPOD_AUDIO_W 8

// Seven-segment digits on the board
`define IPOD_HEX_DIGITS 6

`endif

// ==== source/ipod_pkg.sv ====
`include "ipod_macros.svh"

package ipod_pkg;

  // ======================================================================
  // Speed command opcodes from the key side to the controller
  // ======================================================================
  typedef enum logic [1:0]
  {
    cmd_none  = 2'd0,
    cmd_up    = 2'd1,
    cmd_down  = 2'd2,
    cmd_reset = 2'd3
  } speed_cmd_t;

  // ======================================================================
  // Sample period in CLK_50M cycles
  // ======================================================================

  // Shared by controller, divider, display and top
  typedef logic [`IPOD_PERIOD_W-1:0] period_t;

endpackage

// ==== source/speed_key_input.sv ====
`timescale 1ns/1ps

`include "ipod_macros.svh"

module speed_key_input
  import ipod_pkg::*;
#(
  parameter int key_tick_cycles = 50000
)
(
  input  logic       CLK_50M,
  input  logic       reset,
  input  logic       key_up_n,
  input  logic       key_down_n,
  input  logic       key_reset_n,
  output speed_cmd_t speed_cmd
);

  localparam int tick_w   = (key_tick_cycles > 1) ? $clog2(key_tick_cycles) : 1;
  localparam int window_w = $clog2(`IPOD_EVENT_GAP_TICKS);

  // Keys as active high, bit 0 up, bit 1 down, bit 2 reset
  logic [2:0]          key_meta;
  logic [2:0]          key_sync;
  logic [tick_w-1:0]   tick_cnt;
  logic                key_tick;
  logic [window_w-1:0] window_cnt;
  logic                window_end;
  logic                up_held;
  logic                down_held;
  logic                reset_held;

  // ======================================================================
  // Two-flop synchronizers
  // ======================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= ~{key_reset_n, key_down_n, key_up_n};
      key_sync <= key_meta;
    end
  end

  assign up_held    = key_sync[0];
  assign down_held  = key_sync[1];
  assign reset_held = key_sync[2];

  // ======================================================================
  // Key tick and command window
  // ======================================================================
  assign key_tick   = (tick_cnt == tick_w'(key_tick_cycles - 1));
  assign window_end = key_tick && (window_cnt == window_w'(`IPOD_EVENT_GAP_TICKS - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      tick_cnt   <= '0;
      window_cnt <= '0;
    end
    else
    begin
      tick_cnt <= key_tick ? '0 : tick_cnt + 1'b1;
      // Window advances one step per key tick
      if (window_end)
        window_cnt <= '0;
      else if (key_tick)
        window_cnt <= window_cnt + 1'b1;
    end
  end

  // Reset key wins, up/down only at a window end and only if one is held
  always_comb
  begin
    speed_cmd = cmd_none;
    if (reset_held)
      speed_cmd = cmd_reset;
    else if (window_end)
    begin
      if (up_held && !down_held)
        speed_cmd = cmd_up;
      else if (down_held && !up_held)
        speed_cmd = cmd_down;
    end
  end

endmodule

// ==== source/speed_controller.sv ====
`timescale 1ns/1ps

`include "ipod_macros.svh"

module speed_controller
  import ipod_pkg::*;
(
  input  logic       CLK_50M,
  input  logic       reset,
  input  speed_cmd_t speed_cmd,
  output period_t    sample_period
);

  localparam period_t default_period = period_t'(`IPOD_DEFAULT_PERIOD);
  localparam period_t period_step    = period_t'(`IPOD_PERIOD_STEP);
  localparam period_t min_period     = period_t'(`IPOD_MIN_PERIOD);
  localparam period_t max_period     = period_t'(`IPOD_MAX_PERIOD);

  period_t period_next;

  // ======================================================================
  // Next period from the command
  // ======================================================================
  always_comb
  begin
    period_next = sample_period;
    unique case (speed_cmd)
      cmd_up:
      begin
        // Shorter period means faster sample clock
        if (sample_period >= min_period + period_step)
          period_next = sample_period - period_step;
        else
          period_next = min_period;
      end
      cmd_down:
      begin
        if (sample_period <= max_period - period_step)
          period_next = sample_period + period_step;
        else
          period_next = max_period;
      end
      cmd_reset:
      begin
        period_next = default_period;
      end
      default:
      begin
        period_next = sample_period;
      end
    endcase
  end

  // ======================================================================
  // Period register
  // ======================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      sample_period <= default_period;
    else
      sample_period <= period_next;
  end

endmodule

// ==== source/sample_clock_gen.sv ====
`timescale 1ns/1ps

`include "ipod_macros.svh"

module sample_clock_gen
  import ipod_pkg::*;
(
  input  logic                     CLK_50M,
  input  logic                     reset,
  input  period_t                  sample_period,
  output logic                     sample_clk,
  output logic [`IPOD_AUDIO_W-1:0] audio_sample
);

  // Signed extremes, 8'h80 low and 8'h7F high for an 8-bit sample
  localparam logic [`IPOD_AUDIO_W-1:0] audio_low  = {1'b1, {(`IPOD_AUDIO_W-1){1'b0}}};
  localparam logic [`IPOD_AUDIO_W-1:0] audio_high = {1'b0, {(`IPOD_AUDIO_W-1){1'b1}}};

  period_t div_cnt;
  logic    div_wrap;

  // ======================================================================
  // Period divider
  // ======================================================================

  // Greater-or-equal catches a period that shrank below the count
  assign div_wrap = (div_cnt >= sample_period);

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      div_cnt <= '0;
    else if (div_wrap)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  // ======================================================================
  // Sample clock and test audio
  // ======================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      sample_clk   <= 1'b0;
      audio_sample <= audio_low;
    end
    else if (div_wrap)
    begin
      sample_clk   <= ~sample_clk;
      // Level after the toggle picks the sample
      audio_sample <= sample_clk ? audio_low : audio_high;
    end
  end

endmodule

// ==== source/hex_display.sv ====
`timescale 1ns/1ps

`include "ipod_macros.svh"

module hex_display
  import ipod_pkg::*;
#(
  parameter int display_tick_cycles = 25000000
)
(
  input  logic       CLK_50M,
  input  logic       reset,
  input  period_t    sample_period,
  output logic [6:0] hex0,
  output logic [6:0] hex1,
  output logic [6:0] hex2,
  output logic [6:0] hex3,
  output logic [6:0] hex4,
  output logic [6:0] hex5
);

  localparam int disp_w  = (display_tick_cycles > 1) ? $clog2(display_tick_cycles) : 1;
  localparam int value_w = 4 * `IPOD_HEX_DIGITS;

  logic [disp_w-1:0]  disp_cnt;
  logic               disp_tick;
  period_t            shown_period;
  logic [value_w-1:0] shown_value;
  logic [6:0]         seg [`IPOD_HEX_DIGITS];

  // Active low segments, order gfedcba
  function automatic logic [6:0] seg_decode(input logic [3:0] nibble);
    case (nibble)
      4'h0:    return 7'b1000000;
      4'h1:    return 7'b1111001;
      4'h2:    return 7'b0100100;
      4'h3:    return 7'b0110000;
      4'h4:    return 7'b0011001;
      4'h5:    return 7'b0010010;
      4'h6:    return 7'b0000010;
      4'h7:    return 7'b1111000;
      4'h8:    return 7'b0000000;
      4'h9:    return 7'b0010000;
      4'hA:    return 7'b0001000;
      4'hB:    return 7'b0000011;
      4'hC:    return 7'b1000110;
      4'hD:    return 7'b0100001;
      4'hE:    return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  // ======================================================================
  // Slow snapshot of the period
  // ======================================================================
  assign disp_tick = (disp_cnt == disp_w'(display_tick_cycles - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      disp_cnt     <= '0;
      shown_period <= '0;
    end
    else
    begin
      disp_cnt <= disp_tick ? '0 : disp_cnt + 1'b1;
      if (disp_tick)
        shown_period <= sample_period;
    end
  end

  // Upper digits stay at zero
  assign shown_value = value_w'(shown_period);

  // One decoder per digit, digit 0 is the lowest nibble
  for (genvar d = 0; d < `IPOD_HEX_DIGITS; d++)
  begin : g_digit
    assign seg[d] = seg_decode(shown_value[4*d +: 4]);
  end

  assign hex0 = seg[0];
  assign hex1 = seg[1];
  assign hex2 = seg[2];
  assign hex3 = seg[3];
  assign hex4 = seg[4];
  assign hex5 = seg[5];

endmodule

// ==== source/ipod_speed_top.sv ====
`timescale 1ns/1ps

`include "ipod_macros.svh"

module ipod_speed_top
  import ipod_pkg::*;
#(
  parameter int key_tick_cycles     = 50000,
  parameter int display_tick_cycles = 25000000
)
(
  input  logic                     CLK_50M,
  input  logic                     reset,
  input  logic                     key_up_n,
  input  logic                     key_down_n,
  input  logic                     key_reset_n,
  output logic                     sample_clk,
  output logic [`IPOD_AUDIO_W-1:0] audio_sample,
  output logic [6:0]               hex0,
  output logic [6:0]               hex1,
  output logic [6:0]               hex2,
  output logic [6:0]               hex3,
  output logic [6:0]               hex4,
  output logic [6:0]               hex5
);

  speed_cmd_t speed_cmd;
  period_t    sample_period;

  // ======================================================================
  // Input side
  // ======================================================================
  speed_key_input #(
    .key_tick_cycles (key_tick_cycles)
  ) key_in0 (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .key_up_n    (key_up_n),
    .key_down_n  (key_down_n),
    .key_reset_n (key_reset_n),
    .speed_cmd   (speed_cmd)
  );

  // ======================================================================
  // Period register and sample clock
  // ======================================================================
  speed_controller speed_ctrl0 (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .speed_cmd     (speed_cmd),
    .sample_period (sample_period)
  );

  sample_clock_gen clk_gen0 (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .sample_period (sample_period),
    .sample_clk    (sample_clk),
    .audio_sample  (audio_sample)
  );

  // ======================================================================
  // Output side
  // ======================================================================
  hex_display #(
    .display_tick_cycles (display_tick_cycles)
  ) hex_disp0 (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .sample_period (sample_period),
    .hex0          (hex0),
    .hex1          (hex1),
    .hex2          (hex2),
    .hex3          (hex3),
    .hex4          (hex4),
    .hex5          (hex5)
  );

endmodule

// ==== verification/ipod_properties.sv ====
`timescale 1ns/1ps

`include "ipod_macros.svh"

module ipod_properties
  import ipod_pkg::*;
(
  input logic                     CLK_50M,
  input logic                     reset,
  input logic                     sample_clk,
  input logic [`IPOD_AUDIO_W-1:0] audio_sample,
  input period_t                  sample_period,
  input speed_cmd_t               speed_cmd
);

  // Test audio sits at the signed extremes, following the clock level
  audio_level_a: assert property (@(posedge CLK_50M) disable iff (reset)
    audio_sample == (sample_clk ? 8'h7F : 8'h80))
    else $error("audio_sample does not follow sample_clk");

  period_range_a: assert property (@(posedge CLK_50M) disable iff (reset)
    sample_period >= `IPOD_MIN_PERIOD && sample_period <= `IPOD_MAX_PERIOD)
    else $error("sample_period outside its limits");

  // At most one step per window
  single_step_a: assert property (@(posedge CLK_50M) disable iff (reset)
    (speed_cmd inside {cmd_up, cmd_down}) |=> !(speed_cmd inside {cmd_up, cmd_down}))
    else $error("step commands on consecutive cycles");

endmodule

bind ipod_speed_top ipod_properties props0 (
  .CLK_50M       (CLK_50M),
  .reset         (reset),
  .sample_clk    (sample_clk),
  .audio_sample  (audio_sample),
  .sample_period (sample_period),
  .speed_cmd     (speed_cmd)
);

// ==== verification/ipod_tb.sv ====
`timescale 1ns/1ps

`include "ipod_macros.svh"

module ipod_tb;

  localparam int window_cycles  = 4 * `IPOD_EVENT_GAP_TICKS;
  localparam int display_cycles = 200;
  // Worst-case windows of tests 1 to 5 times two
  localparam int timeout_cycles = 2 * window_cycles * (1 + 124 + 410 + 12 + 125);

  // Active high segment patterns gfedcba for 0 to F
  localparam logic [6:0] seg_lit [16] = '{
    7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
    7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
  };

  logic        CLK_50M;
  logic        reset;
  logic        key_up_n;
  logic        key_down_n;
  logic        key_reset_n;
  logic        sample_clk;
  logic [7:0]  audio_sample;
  logic [41:0] hex_all;
  int          cyc = 0;
  int          run_cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          exp_period = `IPOD_DEFAULT_PERIOD;
  logic [31:0] lfsr = 32'h3025_8ac8;

  ipod_speed_top #(
    .key_tick_cycles     (4),
    .display_tick_cycles (display_cycles)
  ) dut0 (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .key_up_n     (key_up_n),
    .key_down_n   (key_down_n),
    .key_reset_n  (key_reset_n),
    .sample_clk   (sample_clk),
    .audio_sample (audio_sample),
    .hex0         (hex_all[6:0]),
    .hex1         (hex_all[13:7]),
    .hex2         (hex_all[20:14]),
    .hex3         (hex_all[27:21]),
    .hex4         (hex_all[34:28]),
    .hex5         (hex_all[41:35])
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // Cycle index since reset mirrors the key tick and window counters
  always @(posedge CLK_50M)
  begin
    if (reset)
      cyc <= 0;
    else
      cyc <= cyc + 1;
  end

  always @(posedge CLK_50M)
  begin
    run_cycles <= run_cycles + 1;
    if (run_cycles > timeout_cycles)
    begin
      $display("Timeout: no verdict after %0d clock cycles", run_cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output int unsigned val);
    val = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      val = {val[30:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("Mismatch at %0t: %s = %0h, expected %0h", $time, name, got, expected);
    end
  endtask

  // Returns at the falling edge inside the wanted cycle
  task automatic wait_cycle_pos(input int modulus, input int pos);
    do
      @(negedge CLK_50M);
    while (cyc % modulus != pos);
  endtask

  task automatic drive_keys(input logic up, input logic down, input logic rst);
    @(posedge CLK_50M);
    key_up_n    <= ~up;
    key_down_n  <= ~down;
    key_reset_n <= ~rst;
  endtask

  // Keys change only at mid-window
  task automatic hold_keys(input logic up, input logic down, input int windows);
    wait_cycle_pos(window_cycles, window_cycles / 2);
    drive_keys(up, down, 1'b0);
    for (int w = 0; w < windows; w++)
    begin
      wait_cycle_pos(window_cycles, window_cycles / 4);
      if (up && !down)
        exp_period = (exp_period - `IPOD_PERIOD_STEP < `IPOD_MIN_PERIOD) ?
                     `IPOD_MIN_PERIOD : exp_period - `IPOD_PERIOD_STEP;
      else if (down && !up)
        exp_period = (exp_period + `IPOD_PERIOD_STEP > `IPOD_MAX_PERIOD) ?
                     `IPOD_MAX_PERIOD : exp_period + `IPOD_PERIOD_STEP;
      check_value("sample_period", 32'(dut0.sample_period), exp_period);
    end
    wait_cycle_pos(window_cycles, window_cycles / 2);
    drive_keys(1'b0, 1'b0, 1'b0);
  endtask

  task automatic press_reset_key(input int len);
    wait_cycle_pos(window_cycles, window_cycles / 2);
    drive_keys(1'b0, 1'b0, 1'b1);
    repeat (len) @(posedge CLK_50M);
    key_reset_n <= 1'b1;
    exp_period = `IPOD_DEFAULT_PERIOD;
    // Two synchronizer flops and the period register
    repeat (4) @(negedge CLK_50M);
    check_value("sample_period", 32'(dut0.sample_period), exp_period);
  endtask

  task automatic check_hex(input logic [23:0] value);
    for (int d = 0; d < `IPOD_HEX_DIGITS; d++)
      check_value($sformatf("hex%0d", d), 32'(hex_all[7*d +: 7]),
                  {25'd0, ~seg_lit[value[4*d +: 4]]});
  endtask

  task automatic check_digits();
    wait_cycle_pos(display_cycles, 0);
    check_hex(24'(exp_period));
  endtask

  task automatic count_level(input logic level, output int len);
    len = 0;
    while (sample_clk == level)
    begin
      check_value("audio_sample", 32'(audio_sample), sample_clk ? 32'h7F : 32'h80);
      len++;
      @(negedge CLK_50M);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("%s: %0d mismatches", name, errors - errors_before);
  endtask

  // ======================================================================
  // Test sequence
  // ======================================================================
  initial
  begin
    int unsigned n;
    int          start_err;
    int          high_len;
    int          low_len;
    reset       = 1'b1;
    key_up_n    = 1'b1;
    key_down_n  = 1'b1;
    key_reset_n = 1'b1;
    repeat (5) @(posedge CLK_50M);
    reset <= 1'b0;

    start_err = errors;
    @(negedge CLK_50M);
    check_value("sample_clk", 32'(sample_clk), 32'h0);
    check_value("audio_sample", 32'(audio_sample), 32'h80);
    check_hex(24'h0);
    check_digits();
    report_test("Test 1 reset state", start_err);

    start_err = errors;
    take_bits(5, n);
    hold_keys(1'b1, 1'b0, 90 + n);
    check_digits();
    report_test("Test 2 up to min clamp", start_err);

    start_err = errors;
    press_reset_key(4);
    take_bits(4, n);
    hold_keys(1'b0, 1'b1, 376 + n);
    // Off the clamp so a stray step in either direction shows
    hold_keys(1'b1, 1'b0, 1);
    hold_keys(1'b1, 1'b1, 3);
    hold_keys(1'b0, 1'b0, 3);
    check_digits();
    report_test("Test 3 down to max clamp, both and none", start_err);

    start_err = errors;
    take_bits(3, n);
    hold_keys(1'b1, 1'b0, 1 + n);
    take_bits(4, n);
    press_reset_key(1 + n);
    check_digits();
    report_test("Test 4 reset key", start_err);

    // Partial phases are skipped before measuring
    start_err = errors;
    count_level(1'b1, high_len);
    count_level(1'b0, low_len);
    count_level(1'b1, high_len);
    count_level(1'b0, low_len);
    check_value("sample_clk high phase", high_len, exp_period + 1);
    check_value("sample_clk low phase", low_len, exp_period + 1);
    report_test("Test 5 sample clock phases", start_err);

    $display("Checks: %0d, mismatches: %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+include
source/ipod_pkg.sv
source/speed_key_input.sv
source/speed_controller.sv
source/sample_clock_gen.sv
source/hex_display.sv
source/ipod_speed_top.sv
verification/ipod_properties.sv
verification/ipod_tb.sv

// ==== Makefile ====
SIM_BIN := obj_dir/Vipod_tb
SOURCES := compile.f $(wildcard include/*.svh source/*.sv verification/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f --top-module ipod_tb

run: $(SIM_BIN)
	$(SIM_BIN) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
